//--- hdl/cache_pkg.sv
package cache_pkg;

  // ----------------------------------------
  // address layout
  // ----------------------------------------
  // vaddr [31:18] virtual page, looked up in the translation table
  // vaddr [17:10] translation index
  // vaddr [9:3]   cache line index, taken before translation
  // vaddr [2]     word within the line
  localparam int vaddr_w    = 32;
  localparam int page_w     = 14;
  localparam int xlat_idx_w = 8;
  localparam int line_idx_w = 7;

  // physical page plus translation index
  localparam int tag_w      = 22;
  localparam int word_w     = 32;

  // ----------------------------------------
  // cpu request operations
  // ----------------------------------------
  typedef enum logic [1:0] {
    op_read,
    op_write,
    op_xlat_load
  } cpu_op_t;

  // controller states
  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_fill0,
    st_fill1,
    st_wthru,
    st_resp
  } ctrl_state_t;

endpackage

//--- hdl/mem_pkg.sv
package mem_pkg;

  // ----------------------------------------
  // external memory bus
  // ----------------------------------------
  // word address, physical bits 27:2
  localparam int mem_addr_w = 26;

  // one command per handshake
  typedef enum logic {
    mem_rd,
    mem_wr
  } mem_op_t;

endpackage

//--- hdl/xlat_table.sv
`timescale 1ns/100ps

module xlat_table (
  input  logic                            CPU_CLK,
  input  logic                            RST,
  input  logic [cache_pkg::xlat_idx_w-1:0] rd_idx,
  output logic [cache_pkg::page_w-1:0]     rd_vtag,
  output logic [cache_pkg::page_w-1:0]     rd_page,
  output logic                            rd_valid,
  input  logic                            wr_en,
  input  logic [cache_pkg::xlat_idx_w-1:0] wr_idx,
  input  logic [cache_pkg::page_w-1:0]     wr_vtag,
  input  logic [cache_pkg::page_w-1:0]     wr_page
);

  import cache_pkg::*;

  logic [page_w-1:0]         vtag_mem [2**xlat_idx_w];
  logic [page_w-1:0]         page_mem [2**xlat_idx_w];
  logic [2**xlat_idx_w-1:0]  valid;

  // entry storage
  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      vtag_mem[wr_idx] <= wr_vtag;
      page_mem[wr_idx] <= wr_page;
    end
    rd_vtag <= vtag_mem[rd_idx];
    rd_page <= page_mem[rd_idx];
  end

  // valid bits and registered valid read
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid    <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      // read sees the old bit on a same-index write
      rd_valid <= valid[rd_idx];
      if (wr_en)
        valid[wr_idx] <= 1'b1;
    end
  end

  // the controller's fault decision depends on a known valid bit
  a_valid_known: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    !$isunknown(rd_valid)
  );

endmodule

//--- hdl/line_store.sv
`timescale 1ns/100ps

module line_store (
  input  logic                            CPU_CLK,
  input  logic                            RST,
  input  logic [cache_pkg::line_idx_w-1:0] rd_line,
  input  logic                            rd_word,
  output logic [cache_pkg::word_w-1:0]     rd_data,
  output logic [cache_pkg::tag_w-1:0]      rd_tag,
  output logic                            rd_tvalid,
  input  logic                            data_we,
  input  logic [cache_pkg::line_idx_w-1:0] wr_line,
  input  logic                            wr_word,
  input  logic [cache_pkg::word_w-1:0]     wr_data,
  input  logic                            tag_we,
  input  logic [cache_pkg::tag_w-1:0]      wr_tag
);

  import cache_pkg::*;

  // two words per line
  logic [word_w-1:0]         data_mem [2**(line_idx_w+1)];
  logic [tag_w-1:0]          tag_mem  [2**line_idx_w];
  logic [2**line_idx_w-1:0]  tvalid;

  // ----------------------------------------
  // data array
  // ----------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (data_we)
      data_mem[{wr_line, wr_word}] <= wr_data;
    rd_data <= data_mem[{rd_line, rd_word}];
  end

  // ----------------------------------------
  // tag array
  // ----------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (tag_we)
      tag_mem[wr_line] <= wr_tag;
    rd_tag <= tag_mem[rd_line];
  end

  // line valid, set by a tag write
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      tvalid    <= '0;
      rd_tvalid <= 1'b0;
    end
    else
    begin
      rd_tvalid <= tvalid[rd_line];
      if (tag_we)
        tvalid[wr_line] <= 1'b1;
    end
  end

endmodule

//--- hdl/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl (
  input  logic                              CPU_CLK,
  input  logic                              RST,
  // cpu side
  input  logic                              req_valid,
  output logic                              req_ready,
  input  cache_pkg::cpu_op_t                req_op,
  input  logic [cache_pkg::vaddr_w-1:0]      req_vaddr,
  input  logic [cache_pkg::word_w-1:0]       req_wdata,
  output logic                              resp_valid,
  output logic                              resp_fault,
  output logic [cache_pkg::word_w-1:0]       resp_rdata,
  // memory side
  output logic                              mem_valid,
  input  logic                              mem_ready,
  output mem_pkg::mem_op_t                  mem_op,
  output logic [mem_pkg::mem_addr_w-1:0]     mem_addr,
  output logic [cache_pkg::word_w-1:0]       mem_wdata,
  input  logic                              mem_rvalid,
  input  logic [cache_pkg::word_w-1:0]       mem_rdata,
  // translation table
  output logic [cache_pkg::xlat_idx_w-1:0]   xt_rd_idx,
  input  logic [cache_pkg::page_w-1:0]       xt_rd_vtag,
  input  logic [cache_pkg::page_w-1:0]       xt_rd_page,
  input  logic                              xt_rd_valid,
  output logic                              xt_wr_en,
  output logic [cache_pkg::xlat_idx_w-1:0]   xt_wr_idx,
  output logic [cache_pkg::page_w-1:0]       xt_wr_vtag,
  output logic [cache_pkg::page_w-1:0]       xt_wr_page,
  // line store
  output logic [cache_pkg::line_idx_w-1:0]   ls_rd_line,
  output logic                              ls_rd_word,
  input  logic [cache_pkg::word_w-1:0]       ls_rd_data,
  input  logic [cache_pkg::tag_w-1:0]        ls_rd_tag,
  input  logic                              ls_rd_tvalid,
  output logic                              ls_data_we,
  output logic [cache_pkg::line_idx_w-1:0]   ls_wr_line,
  output logic                              ls_wr_word,
  output logic [cache_pkg::word_w-1:0]       ls_wr_data,
  output logic                              ls_tag_we,
  output logic [cache_pkg::tag_w-1:0]        ls_wr_tag
);

  import cache_pkg::*;
  import mem_pkg::*;

  ctrl_state_t           state;
  logic                  cmd_sent;
  cpu_op_t               op_q;
  logic [vaddr_w-1:0]    vaddr_q;
  logic [word_w-1:0]     wdata_q;
  logic [page_w-1:0]     page_q;
  logic [word_w-1:0]     rdata_q;
  logic                  fault_q;
  logic                  xlat_hit;
  logic                  line_hit;
  logic                  filling;
  logic [mem_addr_w-1:0] word_addr;

  // ----------------------------------------
  // lookup decision, tables valid in st_lookup
  // ----------------------------------------
  assign xlat_hit  = xt_rd_valid && (xt_rd_vtag == vaddr_q[31:18]);
  assign line_hit  = ls_rd_tvalid && (ls_rd_tag == {xt_rd_page, vaddr_q[17:10]});
  assign filling   = (state == st_fill0) || (state == st_fill1);
  // physical bits 27:2
  assign word_addr = {page_q[9:0], vaddr_q[17:2]};

  // table reads straight from the request
  assign xt_rd_idx  = req_vaddr[17:10];
  assign ls_rd_line = req_vaddr[9:3];
  assign ls_rd_word = req_vaddr[2];

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state    <= st_idle;
      cmd_sent <= 1'b0;
      fault_q  <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
          if (req_valid)
            state <= st_lookup;
        st_lookup:
        begin
          fault_q <= (op_q != op_xlat_load) && !xlat_hit;
          if (op_q == op_xlat_load || !xlat_hit)
            state <= st_resp;
          else if (op_q == op_write)
            state <= st_wthru;
          else if (line_hit)
            state <= st_resp;
          else
            state <= st_fill0;
        end
        st_fill0, st_fill1:
        begin
          if (mem_valid && mem_ready)
            cmd_sent <= 1'b1;
          // return may coincide with the handshake
          if (mem_rvalid)
          begin
            cmd_sent <= 1'b0;
            state    <= (state == st_fill0) ? st_fill1 : st_resp;
          end
        end
        st_wthru:
          if (mem_ready)
            state <= st_resp;
        default:
          state <= st_idle;
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge CPU_CLK)
  begin
    if (req_valid && req_ready)
    begin
      op_q    <= req_op;
      vaddr_q <= req_vaddr;
      wdata_q <= req_wdata;
    end
    if (state == st_lookup)
    begin
      page_q  <= xt_rd_page;
      rdata_q <= (op_q == op_read) ? ls_rd_data : '0;
    end
    // keep the requested word of the refill
    if (filling && mem_rvalid && ((state == st_fill1) == vaddr_q[2]))
      rdata_q <= mem_rdata;
  end

  assign req_ready  = (state == st_idle);
  assign resp_valid = (state == st_resp);
  assign resp_fault = fault_q;
  assign resp_rdata = rdata_q;

  // ----------------------------------------
  // memory command
  // ----------------------------------------
  assign mem_valid = (filling && !cmd_sent) || (state == st_wthru);
  assign mem_op    = (state == st_wthru) ? mem_wr : mem_rd;
  assign mem_addr  = (state == st_wthru) ? word_addr
                                         : {word_addr[mem_addr_w-1:1], state == st_fill1};
  assign mem_wdata = wdata_q;

  // table writes
  assign xt_wr_en   = (state == st_lookup) && (op_q == op_xlat_load);
  assign xt_wr_idx  = vaddr_q[17:10];
  assign xt_wr_vtag = vaddr_q[31:18];
  assign xt_wr_page = wdata_q[13:0];

  // write hit updates the word in place, misses leave the line alone
  assign ls_data_we = (filling && mem_rvalid) ||
                      ((state == st_lookup) && (op_q == op_write) && xlat_hit && line_hit);
  assign ls_wr_line = vaddr_q[9:3];
  assign ls_wr_word = (state == st_lookup) ? vaddr_q[2] : (state == st_fill1);
  assign ls_wr_data = (state == st_lookup) ? wdata_q : mem_rdata;
  assign ls_tag_we  = (state == st_fill0) && mem_rvalid;
  assign ls_wr_tag  = {page_q, vaddr_q[17:10]};

  // ----------------------------------------
  // protocol checks
  // ----------------------------------------
  a_mem_stable: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr)
  );

  a_rvalid_in_fill: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    mem_rvalid |-> (state inside {st_fill0, st_fill1})
  );

  a_resp_single: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    resp_valid |=> !resp_valid
  );

endmodule

//--- hdl/cache_top.sv
`timescale 1ns/100ps

module cache_top (
  input  logic                          CPU_CLK,
  input  logic                          RST,
  input  logic                          req_valid,
  output logic                          req_ready,
  input  cache_pkg::cpu_op_t            req_op,
  input  logic [cache_pkg::vaddr_w-1:0]  req_vaddr,
  input  logic [cache_pkg::word_w-1:0]   req_wdata,
  output logic                          resp_valid,
  output logic                          resp_fault,
  output logic [cache_pkg::word_w-1:0]   resp_rdata,
  output logic                          mem_valid,
  input  logic                          mem_ready,
  output mem_pkg::mem_op_t              mem_op,
  output logic [mem_pkg::mem_addr_w-1:0] mem_addr,
  output logic [cache_pkg::word_w-1:0]   mem_wdata,
  input  logic                          mem_rvalid,
  input  logic [cache_pkg::word_w-1:0]   mem_rdata
);

  import cache_pkg::*;

  // translation table wiring
  logic [xlat_idx_w-1:0] xt_rd_idx;
  logic [page_w-1:0]     xt_rd_vtag;
  logic [page_w-1:0]     xt_rd_page;
  logic                  xt_rd_valid;
  logic                  xt_wr_en;
  logic [xlat_idx_w-1:0] xt_wr_idx;
  logic [page_w-1:0]     xt_wr_vtag;
  logic [page_w-1:0]     xt_wr_page;

  // line store wiring
  logic [line_idx_w-1:0] ls_rd_line;
  logic                  ls_rd_word;
  logic [word_w-1:0]     ls_rd_data;
  logic [tag_w-1:0]      ls_rd_tag;
  logic                  ls_rd_tvalid;
  logic                  ls_data_we;
  logic [line_idx_w-1:0] ls_wr_line;
  logic                  ls_wr_word;
  logic [word_w-1:0]     ls_wr_data;
  logic                  ls_tag_we;
  logic [tag_w-1:0]      ls_wr_tag;

  xlat_table u_xlat (
    .CPU_CLK  (CPU_CLK),
    .RST      (RST),
    .rd_idx   (xt_rd_idx),
    .rd_vtag  (xt_rd_vtag),
    .rd_page  (xt_rd_page),
    .rd_valid (xt_rd_valid),
    .wr_en    (xt_wr_en),
    .wr_idx   (xt_wr_idx),
    .wr_vtag  (xt_wr_vtag),
    .wr_page  (xt_wr_page)
  );

  line_store u_lines (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .rd_line   (ls_rd_line),
    .rd_word   (ls_rd_word),
    .rd_data   (ls_rd_data),
    .rd_tag    (ls_rd_tag),
    .rd_tvalid (ls_rd_tvalid),
    .data_we   (ls_data_we),
    .wr_line   (ls_wr_line),
    .wr_word   (ls_wr_word),
    .wr_data   (ls_wr_data),
    .tag_we    (ls_tag_we),
    .wr_tag    (ls_wr_tag)
  );

  cache_ctrl u_ctrl (
    .CPU_CLK      (CPU_CLK),
    .RST          (RST),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req_op       (req_op),
    .req_vaddr    (req_vaddr),
    .req_wdata    (req_wdata),
    .resp_valid   (resp_valid),
    .resp_fault   (resp_fault),
    .resp_rdata   (resp_rdata),
    .mem_valid    (mem_valid),
    .mem_ready    (mem_ready),
    .mem_op       (mem_op),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata    (mem_rdata),
    .xt_rd_idx    (xt_rd_idx),
    .xt_rd_vtag   (xt_rd_vtag),
    .xt_rd_page   (xt_rd_page),
    .xt_rd_valid  (xt_rd_valid),
    .xt_wr_en     (xt_wr_en),
    .xt_wr_idx    (xt_wr_idx),
    .xt_wr_vtag   (xt_wr_vtag),
    .xt_wr_page   (xt_wr_page),
    .ls_rd_line   (ls_rd_line),
    .ls_rd_word   (ls_rd_word),
    .ls_rd_data   (ls_rd_data),
    .ls_rd_tag    (ls_rd_tag),
    .ls_rd_tvalid (ls_rd_tvalid),
    .ls_data_we   (ls_data_we),
    .ls_wr_line   (ls_wr_line),
    .ls_wr_word   (ls_wr_word),
    .ls_wr_data   (ls_wr_data),
    .ls_tag_we    (ls_tag_we),
    .ls_wr_tag    (ls_wr_tag)
  );

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic CPU_CLK
);

  // 10 ns period
  initial
  begin
    CPU_CLK = 1'b0;
    forever
      #5 CPU_CLK = ~CPU_CLK;
  end

endmodule

//--- verif/tb_cache.sv
`timescale 1ns/100ps

module tb_cache;

  import cache_pkg::*;
  import mem_pkg::*;

  localparam int n_random       = 400;
  // a read miss can be followed by one extra read of the same line
  localparam int n_requests     = 4 + 2 * n_random;
  localparam int timeout_cycles = 400 * n_requests;

  logic                  CPU_CLK;
  logic                  RST;
  logic                  req_valid;
  logic                  req_ready;
  cpu_op_t               req_op;
  logic [vaddr_w-1:0]    req_vaddr;
  logic [word_w-1:0]     req_wdata;
  logic                  resp_valid;
  logic                  resp_fault;
  logic [word_w-1:0]     resp_rdata;
  logic                  mem_valid;
  logic                  mem_ready  = 1'b0;
  mem_op_t               mem_op;
  logic [mem_addr_w-1:0] mem_addr;
  logic [word_w-1:0]     mem_wdata;
  logic                  mem_rvalid = 1'b0;
  logic [word_w-1:0]     mem_rdata  = '0;

  logic [31:0]           stim_rng = 32'hdee7_f3ba;
  // separate stream for the memory side
  logic [31:0]           mem_rng  = 32'hdee7_f3ba ^ 32'h0000_ffff;
  int                    err_count = 0;
  int                    cycle_cnt = 0;

  // memory seen by the bus, and the model's image of it
  logic [word_w-1:0]     mem_store [logic [mem_addr_w-1:0]];
  logic [word_w-1:0]     img [logic [mem_addr_w-1:0]];

  // model translation table and cache lines
  logic                  xv_valid [256];
  logic [page_w-1:0]     xv_tag   [256];
  logic [page_w-1:0]     xv_page  [256];
  logic                  lv [128];
  logic [tag_w-1:0]      lt [128];

  // commands seen on the bus and commands expected
  mem_op_t               cmd_op_q[$];
  logic [mem_addr_w-1:0] cmd_addr_q[$];
  logic [word_w-1:0]     cmd_data_q[$];
  mem_op_t               exp_op_q[$];
  logic [mem_addr_w-1:0] exp_addr_q[$];
  logic [word_w-1:0]     exp_data_q[$];

  // responder state
  logic                  rd_pending = 1'b0;
  int                    rd_wait = 0;
  logic [mem_addr_w-1:0] rd_addr;
  logic                  held = 1'b0;
  mem_op_t               held_op;
  logic [mem_addr_w-1:0] held_addr;
  logic [word_w-1:0]     held_data;

  tb_clock u_clk (
    .CPU_CLK (CPU_CLK)
  );

  cache_top DUT (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_op     (req_op),
    .req_vaddr  (req_vaddr),
    .req_wdata  (req_wdata),
    .resp_valid (resp_valid),
    .resp_fault (resp_fault),
    .resp_rdata (resp_rdata),
    .mem_valid  (mem_valid),
    .mem_ready  (mem_ready),
    .mem_op     (mem_op),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // lcg step returning a value below n
  function automatic int pick(inout logic [31:0] s, input int n);
    s = s * 32'd1664525 + 32'd1013904223;
    return int'({16'd0, s[31:16]}) % n;
  endfunction

  // initial memory content is a hash of the word address
  function automatic logic [word_w-1:0] init_word(input logic [mem_addr_w-1:0] a);
    return ({6'd0, a} * 32'h9e37_79b1) ^ {a, 6'h2d};
  endfunction

  function automatic logic [word_w-1:0] read_img(input logic [mem_addr_w-1:0] a);
    if (img.exists(a))
      return img[a];
    return init_word(a);
  endfunction

  function automatic logic [word_w-1:0] read_mem(input logic [mem_addr_w-1:0] a);
    if (mem_store.exists(a))
      return mem_store[a];
    return init_word(a);
  endfunction

  // small pools so that hits and conflicts are common
  function automatic logic [vaddr_w-1:0] make_vaddr(input int t, input int x,
                                                    input int l, input int w);
    return {10'h2c5, 4'(t), 8'(x + 'h30), 7'(l * 5), 1'(w), 2'b00};
  endfunction

  // low 10 bits differ for every page so no two pages share memory words
  function automatic logic [page_w-1:0] page_of(input int k);
    return {4'(k) ^ 4'h9, 6'h15, 4'(k)};
  endfunction

  task automatic fail_stop(input string what);
    err_count++;
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(input string name, input logic [word_w-1:0] got,
                            input logic [word_w-1:0] exp);
    if (got !== exp)
      fail_stop($sformatf("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp));
  endtask

  task automatic check_fault(input logic got, input logic exp);
    if (got !== exp)
      fail_stop($sformatf("MISMATCH time=%0t resp_fault got=%b exp=%b", $time, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_stop($sformatf("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp));
  endtask

  task automatic check_mem_cmd(input mem_op_t got_op, input logic [mem_addr_w-1:0] got_addr,
                               input mem_op_t exp_op, input logic [mem_addr_w-1:0] exp_addr);
    if (got_op !== exp_op || got_addr !== exp_addr)
      fail_stop($sformatf("MISMATCH time=%0t mem_cmd got=%s/%h exp=%s/%h", $time,
                          got_op.name(), got_addr, exp_op.name(), exp_addr));
  endtask

  task automatic expect_cmd(input mem_op_t op, input logic [mem_addr_w-1:0] a,
                            input logic [word_w-1:0] d);
    exp_op_q.push_back(op);
    exp_addr_q.push_back(a);
    exp_data_q.push_back(d);
  endtask

  // ----------------------------------------
  // one cpu request against the model
  // ----------------------------------------
  task automatic run_request(input cpu_op_t op, input logic [vaddr_w-1:0] va,
                             input logic [word_w-1:0] wd, output logic was_miss);
    logic [xlat_idx_w-1:0] xi;
    logic [line_idx_w-1:0] ln;
    logic                  xhit;
    logic                  exp_fault;
    logic                  fixed_lat;
    logic [mem_addr_w-1:0] wa;
    logic [tag_w-1:0]      ptag;
    logic [word_w-1:0]     exp_data;
    logic [word_w-1:0]     got_d;
    logic [word_w-1:0]     exp_d;
    mem_op_t               cop;
    int                    lat;
    xi        = va[17:10];
    ln        = va[9:3];
    xhit      = xv_valid[xi] && (xv_tag[xi] == va[31:18]);
    wa        = {xv_page[xi][9:0], va[17:2]};
    ptag      = {xv_page[xi], va[17:10]};
    exp_fault = (op != op_xlat_load) && !xhit;
    exp_data  = read_img(wa);
    fixed_lat = 1'b1;
    was_miss  = 1'b0;
    if (op == op_xlat_load)
    begin
      xv_valid[xi] = 1'b1;
      xv_tag[xi]   = va[31:18];
      xv_page[xi]  = wd[13:0];
    end
    else if (xhit && op == op_write)
    begin
      fixed_lat = 1'b0;
      img[wa]   = wd;
      expect_cmd(mem_wr, wa, wd);
    end
    else if (xhit && !(lv[ln] && lt[ln] == ptag))
    begin
      // read miss refills both words
      fixed_lat = 1'b0;
      was_miss  = 1'b1;
      expect_cmd(mem_rd, {wa[mem_addr_w-1:1], 1'b0}, '0);
      expect_cmd(mem_rd, {wa[mem_addr_w-1:1], 1'b1}, '0);
      lv[ln] = 1'b1;
      lt[ln] = ptag;
    end

    req_valid = 1'b1;
    req_op    = op;
    req_vaddr = va;
    req_wdata = wd;
    while (!req_ready)
      @(negedge CPU_CLK);
    @(negedge CPU_CLK);
    req_valid = 1'b0;
    lat = 1;
    while (!resp_valid)
    begin
      @(negedge CPU_CLK);
      lat++;
    end

    if (fixed_lat && lat != 2)
      fail_stop($sformatf("response to %s at %h came %0d cycles after acceptance, not 2",
                          op.name(), va, lat));
    check_fault(resp_fault, exp_fault);
    if (op == op_read && !exp_fault)
      check_word("resp_rdata", resp_rdata, exp_data);
    if (cmd_op_q.size() != exp_op_q.size())
      fail_stop($sformatf("%s at %h made %0d memory commands instead of %0d",
                          op.name(), va, cmd_op_q.size(), exp_op_q.size()));
    while (exp_op_q.size() > 0)
    begin
      cop = exp_op_q.pop_front();
      check_mem_cmd(cmd_op_q.pop_front(), cmd_addr_q.pop_front(), cop, exp_addr_q.pop_front());
      got_d = cmd_data_q.pop_front();
      exp_d = exp_data_q.pop_front();
      if (cop == mem_wr)
        check_word("mem_wdata", got_d, exp_d);
    end
  endtask

  // ----------------------------------------
  // memory responder
  // ----------------------------------------
  always @(negedge CPU_CLK)
  begin
    if (!RST)
    begin
      mem_ready  = 1'b0;
      mem_rvalid = 1'b0;
      held       = 1'b0;
    end
    else
    begin
      mem_rvalid = 1'b0;
      if (rd_pending)
      begin
        if (rd_wait == 0)
        begin
          mem_rvalid = 1'b1;
          mem_rdata  = read_mem(rd_addr);
          rd_pending = 1'b0;
        end
        else
          rd_wait--;
      end
      // stalled command must hold still
      if (held)
      begin
        check_flag("mem_valid", mem_valid, 1'b1);
        check_mem_cmd(mem_op, mem_addr, held_op, held_addr);
        check_word("mem_wdata", mem_wdata, held_data);
      end
      mem_ready = (pick(mem_rng, 4) != 0);
      held      = mem_valid && !mem_ready;
      held_op   = mem_op;
      held_addr = mem_addr;
      held_data = mem_wdata;
      if (mem_valid && mem_ready)
      begin
        if (mem_op == mem_rd && rd_pending)
          fail_stop("a memory read was issued before the previous read returned");
        cmd_op_q.push_back(mem_op);
        cmd_addr_q.push_back(mem_addr);
        cmd_data_q.push_back(mem_wdata);
        if (mem_op == mem_wr)
          mem_store[mem_addr] = mem_wdata;
        else
        begin
          rd_pending = 1'b1;
          rd_addr    = mem_addr;
          rd_wait    = pick(mem_rng, 4);
        end
      end
    end
  end

  always @(posedge CPU_CLK)
  begin
    cycle_cnt++;
    if (cycle_cnt > timeout_cycles)
      fail_stop($sformatf("timeout, requests still running after %0d cycles", cycle_cnt));
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial
  begin
    logic [vaddr_w-1:0] va;
    logic [word_w-1:0]  wd;
    logic               miss;
    int                 k;
    int                 r;
    int                 n;
    RST       = 1'b0;
    req_valid = 1'b0;
    req_op    = op_read;
    req_vaddr = '0;
    req_wdata = '0;
    for (k = 0; k < 256; k++)
    begin
      xv_valid[k] = 1'b0;
      xv_tag[k]   = '0;
      xv_page[k]  = '0;
    end
    for (k = 0; k < 128; k++)
    begin
      lv[k] = 1'b0;
      lt[k] = '0;
    end
    repeat (3) @(negedge CPU_CLK);
    RST = 1'b1;
    @(negedge CPU_CLK);
    check_flag("req_ready", req_ready, 1'b1);
    check_flag("resp_valid", resp_valid, 1'b0);
    check_flag("mem_valid", mem_valid, 1'b0);

    // one translation per table index to start with
    for (k = 0; k < 4; k++)
      run_request(op_xlat_load, make_vaddr(0, k, 0, 0), {18'h0, page_of(k)}, miss);

    for (k = 0; k < n_random; k++)
    begin
      r = pick(stim_rng, 100);
      n = pick(stim_rng, 128);
      va = make_vaddr(n % 2, (n / 2) % 4, (n / 8) % 8, (n / 64) % 2);
      wd[15:0]  = 16'(pick(stim_rng, 65536));
      wd[31:16] = 16'(pick(stim_rng, 65536));
      if (r < 12)
      begin
        wd[13:0] = page_of(pick(stim_rng, 8));
        run_request(op_xlat_load, va, wd, miss);
      end
      else if (r < 45)
        run_request(op_write, va, wd, miss);
      else
      begin
        run_request(op_read, va, wd, miss);
        // read either word of the line just filled
        if (miss)
          run_request(op_read, {va[31:3], 1'(pick(stim_rng, 2)), 2'b00}, wd, miss);
      end
    end

    @(negedge CPU_CLK);
    if (err_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- flist.f
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/xlat_table.sv
hdl/line_store.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
verif/tb_clock.sv
verif/tb_cache.sv

//--- run.sh
#!/bin/sh
# build the cache testbench with Verilator, run it, and look for the pass line
verilator --binary --timing --assert --top-module tb_cache -f flist.f -o sim_cache || exit 1
out=$(./obj_dir/sim_cache)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && echo "run passed" || { echo "run failed"; exit 1; }
